/* all.f */
source/paging_pkg.sv
source/pager_port_decode.sv
source/window_pager.sv
source/address_mapper.sv
source/paging_top.sv
verification/paging_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module paging_tb -f all.f -o sim_paging || exit 1
out=$(./obj_dir/sim_paging 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/paging_tb.sv */
`timescale 1ns/1ps

module paging_tb;

	localparam int CLK_PERIOD    = 100;
	localparam int RST_CYCLES    = 3;
	localparam int NW            = paging_pkg::NUM_WINDOWS;
	localparam int MARGIN_CYCLES = 50;
	localparam logic [7:0] ROM_MASK  = 8'(1 << paging_pkg::P7FFD_ROM_BIT);
	localparam logic [7:0] LOCK_MASK = 8'(1 << paging_pkg::P7FFD_LOCK_BIT);
	// strobe sets as {port_wr, port_rd, mem_rd, m1}
	localparam logic [3:0] IDLE  = 4'b0000;
	localparam logic [3:0] PWR   = 4'b1000;
	localparam logic [3:0] PRD   = 4'b0100;
	localparam logic [3:0] RD    = 4'b0010;
	localparam logic [3:0] FETCH = 4'b0011;
	// resets, 7FFD rounds, pager rounds, bank swaps, readback, dos, tail
	localparam int PLANNED_CYCLES = 2 * (RST_CYCLES + 1) + NW + 7 * (1 + NW)
		+ 1 + 2 * (1 + 4 * 2 * NW) + 2 * (1 + NW) + 14 + 21 + 2;

	logic                               fclk = 1'b0;
	logic                               rst = 1'b1;
	logic [15:0]                        za = '0;
	logic [7:0]                         zd_in = '0;
	logic                               port_wr = 1'b0;
	logic                               port_rd = 1'b0;
	logic                               mem_rd = 1'b0;
	logic                               m1 = 1'b0;
	logic [paging_pkg::PHYS_ADDR_W-1:0] mem_addr;
	logic                               mem_rom;
	logic                               dos;
	logic [7:0]                         rd_data;
	logic                               rd_hit;

	integer      seed = 32'h8a8c;
	logic [31:0] rnd;

	// model state and expected values
	logic [7:0] m_7ffd;
	logic       m_pager_on;
	logic [7:0] m_entry [NW][2];
	logic       m_dos;
	logic [1:0] win_sel;
	logic [8:0] exp_map;
	logic       exp_hit;
	logic [7:0] exp_rd;

	paging_top u_dut (.*);

	initial
	begin
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// {ram, page} of one window
	function automatic logic [8:0] window_map(input logic [1:0] win);
		logic [7:0] e;
		e = m_entry[win][m_7ffd[paging_pkg::P7FFD_ROM_BIT]];
		if (m_pager_on && e[paging_pkg::BIT_RAM] && e[paging_pkg::BIT_FOLLOW])
			return {1'b1, 5'd0, m_7ffd[2:0]};
		if (m_pager_on)
			return {e[paging_pkg::BIT_RAM], 2'b00, e[5:0]};
		if (win == 2'd0)
			return {1'b0, 6'd0, !m_dos, m_7ffd[paging_pkg::P7FFD_ROM_BIT]};
		if (win == 2'd3)
			return {1'b1, 5'd0, m_7ffd[2:0]};
		return {1'b1, (win == 2'd1) ? 8'd5 : 8'd2};
	endfunction

	assign win_sel = za[15:14];
	assign exp_hit = port_rd && (za[7:0] == paging_pkg::PORT_LO_READBACK);

	always_comb exp_map = window_map(win_sel);
	always_comb exp_rd = m_entry[win_sel][za[13]];

	always @(posedge fclk)
	begin
		if (rst)
		begin
			m_7ffd     <= '0;
			m_pager_on <= 1'b0;
			m_dos      <= 1'b0;
			for (int w = 0; w < NW; w++)
			begin
				m_entry[w][0] <= '0;
				m_entry[w][1] <= '0;
			end
		end
		else
		begin
			if (port_wr && za == paging_pkg::PORT_7FFD && !m_7ffd[paging_pkg::P7FFD_LOCK_BIT])
				m_7ffd <= zd_in;
			if (port_wr && za[7:0] == paging_pkg::PORT_LO_ENABLE)
				m_pager_on <= zd_in[0];
			if (port_wr && za[7:0] == paging_pkg::PORT_LO_PAGE)
				m_entry[win_sel][m_7ffd[paging_pkg::P7FFD_ROM_BIT]] <= zd_in;
			// trap only from rom window 0 with the rom bit set
			if (mem_rd && m1 && win_sel == 2'd0 && !exp_map[8]
				&& za[15:8] == paging_pkg::DOS_TRAP_HI && m_7ffd[paging_pkg::P7FFD_ROM_BIT])
				m_dos <= 1'b1;
			else if (mem_rd && m1 && exp_map[8])
				m_dos <= 1'b0;
		end
	end

	a_map: assert property (@(posedge fclk) disable iff (rst)
		{mem_rom, mem_addr} == {!exp_map[8], exp_map[7:0], za[13:0]})
		else report_failure($sformatf("za %h mapped to %h rom %b, expected page %h ram %b",
			$sampled(za), $sampled(mem_addr), $sampled(mem_rom),
			$sampled(exp_map[7:0]), $sampled(exp_map[8])));
	a_dos: assert property (@(posedge fclk) disable iff (rst) dos == m_dos)
		else report_failure($sformatf("dos %b, expected %b", $sampled(dos), $sampled(m_dos)));
	a_readback: assert property (@(posedge fclk) disable iff (rst)
		rd_hit == exp_hit && (!exp_hit || rd_data == exp_rd))
		else report_failure($sformatf("read at %h gave %h hit %b, expected %h hit %b",
			$sampled(za), $sampled(rd_data), $sampled(rd_hit),
			$sampled(exp_rd), $sampled(exp_hit)));

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("Error: %0d ns, %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic drive(input logic [15:0] a, input logic [7:0] d, input logic [3:0] strobes);
		@(posedge fclk);
		za <= a;
		zd_in <= d;
		{port_wr, port_rd, mem_rd, m1} <= strobes;
	endtask

	// one plain read in each window
	task automatic sweep_windows();
		for (int w = 0; w < NW; w++)
		begin
			rnd = $random(seed);
			drive({2'(w), rnd[13:0]}, rnd[21:14], RD);
		end
	endtask

	task automatic apply_reset();
		drive('0, '0, IDLE);
		rst <= 1'b1;
		repeat (RST_CYCLES) @(posedge fclk);
		rst <= 1'b0;
	endtask

	initial
	begin
		repeat (PLANNED_CYCLES + MARGIN_CYCLES) @(posedge fclk);
		$display("Timeout: stimulus still running after %0d clock cycles",
			PLANNED_CYCLES + MARGIN_CYCLES);
		$display("Simulation failed");
		$fatal(1);
	end

	initial
	begin
		apply_reset();
		sweep_windows();

		// four free 7FFD writes, one that locks, two that must be ignored
		for (int i = 0; i < 7; i++)
		begin
			rnd = $random(seed);
			if (i < 4)
				drive(paging_pkg::PORT_7FFD, rnd[7:0] & ~LOCK_MASK, PWR);
			else if (i == 4)
				drive(paging_pkg::PORT_7FFD, rnd[7:0] | LOCK_MASK, PWR);
			else
				drive(paging_pkg::PORT_7FFD, rnd[7:0], PWR);
			sweep_windows();
		end
		apply_reset();

		rnd = $random(seed);
		drive({rnd[15:8], paging_pkg::PORT_LO_ENABLE}, rnd[7:0] | 8'h01, PWR);
		for (int bank = 0; bank < 2; bank++)
		begin
			rnd = $random(seed);
			drive(paging_pkg::PORT_7FFD,
				(rnd[7:0] & ~(LOCK_MASK | ROM_MASK)) | ((bank != 0) ? ROM_MASK : 8'h00), PWR);
			// top two bits walk through rom, ram and follow entries
			for (int kind = 0; kind < 4; kind++)
			begin
				for (int w = 0; w < NW; w++)
				begin
					rnd = $random(seed);
					drive({2'(w), rnd[5:0], paging_pkg::PORT_LO_PAGE}, {2'(kind), rnd[13:8]}, PWR);
				end
				sweep_windows();
			end
		end
		drive(paging_pkg::PORT_7FFD, 8'h06, PWR);
		sweep_windows();
		drive(paging_pkg::PORT_7FFD, ROM_MASK | 8'h03, PWR);
		sweep_windows();

		for (int w = 0; w < NW; w++)
		begin
			rnd = $random(seed);
			drive({2'(w), 1'b0, rnd[4:0], paging_pkg::PORT_LO_READBACK}, rnd[15:8], PRD);
			drive({2'(w), 1'b1, rnd[12:8], paging_pkg::PORT_LO_READBACK}, rnd[15:8], PRD);
			// another port gives no hit
			drive({2'(w), rnd[13:8], (rnd[7:0] == 8'hBE) ? 8'h00 : rnd[7:0]}, 8'h00, PRD);
		end
		drive({8'h12, paging_pkg::PORT_LO_READBACK}, 8'h00, RD);

		// window 0 holds ram here, so a fetch from 3Dxx must not trap
		drive({paging_pkg::DOS_TRAP_HI, rnd[7:0]}, 8'h00, FETCH);

		// pentagon layout again for the dos trap
		drive({rnd[15:8], paging_pkg::PORT_LO_ENABLE}, 8'h00, PWR);
		drive(paging_pkg::PORT_7FFD, 8'h00, PWR);
		drive({paging_pkg::DOS_TRAP_HI, rnd[7:0]}, 8'h00, FETCH);
		sweep_windows();
		drive(paging_pkg::PORT_7FFD, ROM_MASK, PWR);
		drive({paging_pkg::DOS_TRAP_HI, rnd[15:8]}, 8'h00, RD);
		drive({paging_pkg::DOS_TRAP_HI, rnd[7:0]}, 8'h00, FETCH);
		sweep_windows();
		drive({2'b10, rnd[13:0]}, 8'h00, RD);
		drive(16'h0100, 8'h00, FETCH);
		drive({2'b01, rnd[13:0]}, 8'h00, FETCH);
		sweep_windows();
		drive('0, '0, IDLE);
		@(posedge fclk);

		$display("Simulation passed");
		$finish;
	end

endmodule

/* source/paging_top.sv */
`timescale 1ns/1ps

module paging_top (
	input  logic                                fclk,
	input  logic                                rst,

	input  logic [15:0]                         za,
	input  logic [7:0]                          zd_in,
	input  logic                                port_wr,
	input  logic                                port_rd,
	input  logic                                mem_rd,
	input  logic                                m1,

	output logic [paging_pkg::PHYS_ADDR_W-1:0]  mem_addr,
	output logic                                mem_rom,
	output logic                                dos,
	output logic [7:0]                          rd_data,
	output logic                                rd_hit
);

	logic [paging_pkg::NUM_WINDOWS-1:0] page_wr;
	logic [paging_pkg::PAGE_W-1:0]      page_wdata;
	logic                               bank_sel;
	logic                               pager_on;
	logic [2:0]                         pent_page;
	logic                               pent_rom;

	logic [paging_pkg::PAGE_W-1:0]      cur_page [paging_pkg::NUM_WINDOWS];
	logic [paging_pkg::NUM_WINDOWS-1:0] cur_ram;
	logic [paging_pkg::PAGE_W-1:0]      entry0 [paging_pkg::NUM_WINDOWS];
	logic [paging_pkg::PAGE_W-1:0]      entry1 [paging_pkg::NUM_WINDOWS];

	pager_port_decode u_decode (
		.fclk       (fclk),
		.rst        (rst),
		.za         (za),
		.zd_in      (zd_in),
		.port_wr    (port_wr),
		.page_wr    (page_wr),
		.page_wdata (page_wdata),
		.bank_sel   (bank_sel),
		.pager_on   (pager_on),
		.pent_page  (pent_page),
		.pent_rom   (pent_rom)
	);

	////////////////////////////////////////////////////////////////////////////
	// one pager per 16 KB window
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < paging_pkg::NUM_WINDOWS; i++)
	begin : g_win
		window_pager #(
			.WIN_INDEX (i)
		) u_pager (
			.fclk       (fclk),
			.rst        (rst),
			.page_wr    (page_wr[i]),
			.page_wdata (page_wdata),
			.bank_sel   (bank_sel),
			.pager_on   (pager_on),
			.pent_page  (pent_page),
			.pent_rom   (pent_rom),
			.dos        (dos),
			.cur_page   (cur_page[i]),
			.cur_ram    (cur_ram[i]),
			.entry0     (entry0[i]),
			.entry1     (entry1[i])
		);
	end

	// dos goes back to window 0 for its rom page
	address_mapper u_mapper (
		.fclk     (fclk),
		.rst      (rst),
		.za       (za),
		.mem_rd   (mem_rd),
		.m1       (m1),
		.port_rd  (port_rd),
		.cur_page (cur_page),
		.cur_ram  (cur_ram),
		.entry0   (entry0),
		.entry1   (entry1),
		.pent_rom (pent_rom),
		.mem_addr (mem_addr),
		.mem_rom  (mem_rom),
		.dos      (dos),
		.rd_data  (rd_data),
		.rd_hit   (rd_hit)
	);

endmodule

/* source/address_mapper.sv */
`timescale 1ns/1ps

module address_mapper (
	input  logic                                fclk,
	input  logic                                rst,

	// z80 side
	input  logic [15:0]                         za,
	input  logic                                mem_rd,
	input  logic                                m1,
	input  logic                                port_rd,

	// per-window state from the pagers
	input  logic [paging_pkg::PAGE_W-1:0]       cur_page [paging_pkg::NUM_WINDOWS],
	input  logic [paging_pkg::NUM_WINDOWS-1:0]  cur_ram,
	input  logic [paging_pkg::PAGE_W-1:0]       entry0 [paging_pkg::NUM_WINDOWS],
	input  logic [paging_pkg::PAGE_W-1:0]       entry1 [paging_pkg::NUM_WINDOWS],
	input  logic                                pent_rom,

	output logic [paging_pkg::PHYS_ADDR_W-1:0]  mem_addr,
	output logic                                mem_rom,
	output logic                                dos,
	output logic [7:0]                          rd_data,
	output logic                                rd_hit
);

	logic [15-paging_pkg::WIN_OFFSET_W:0] win;
	logic                                 fetch;
	logic                                 dos_on;
	logic                                 dos_off;

	assign win = za[15:paging_pkg::WIN_OFFSET_W];

	////////////////////////////////////////////////////////////////////////////
	// address translation
	////////////////////////////////////////////////////////////////////////////

	assign mem_addr = {cur_page[win], za[paging_pkg::WIN_OFFSET_W-1:0]};
	assign mem_rom  = ~cur_ram[win];

	////////////////////////////////////////////////////////////////////////////
	// dos flag
	////////////////////////////////////////////////////////////////////////////

	assign fetch = mem_rd && m1;

	// trap only in the 48k basic rom, which is window 0 as rom with rom bit set
	assign dos_on  = fetch && (win == '0) && !cur_ram[0] && pent_rom
	                 && (za[15:8] == paging_pkg::DOS_TRAP_HI);
	assign dos_off = fetch && cur_ram[win];

	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	// readback where za[13] picks entry1
	assign rd_hit = port_rd && (za[7:0] == paging_pkg::PORT_LO_READBACK);

	always_comb
	begin
		rd_data = '0;
		if (rd_hit)
			rd_data = za[13] ? entry1[win] : entry0[win];
	end

endmodule

/* source/window_pager.sv */
`timescale 1ns/1ps

module window_pager #(
	parameter int WIN_INDEX = 0
) (
	input  logic                            fclk,
	input  logic                            rst,

	// from the port decoder
	input  logic                            page_wr,
	input  logic [paging_pkg::PAGE_W-1:0]   page_wdata,
	input  logic                            bank_sel,
	input  logic                            pager_on,
	input  logic [2:0]                      pent_page,
	input  logic                            pent_rom,

	// from the mapper
	input  logic                            dos,

	// current mapping of this window
	output logic [paging_pkg::PAGE_W-1:0]   cur_page,
	output logic                            cur_ram,

	// stored entries for readback
	output logic [paging_pkg::PAGE_W-1:0]   entry0,
	output logic [paging_pkg::PAGE_W-1:0]   entry1
);

	logic [paging_pkg::PAGE_W-1:0] entry_sel;
	logic [paging_pkg::PAGE_W-1:0] pent_ram_page;
	logic [paging_pkg::PAGE_W-1:0] pent_rom_page;
	logic                          follow;

	////////////////////////////////////////////////////////////////////////////
	// page entries
	////////////////////////////////////////////////////////////////////////////

	// bank follows the 7FFD rom bit, both for writes and for mapping
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			entry0 <= '0;
			entry1 <= '0;
		end
		else if (page_wr)
		begin
			if (bank_sel)
				entry1 <= page_wdata;
			else
				entry0 <= page_wdata;
		end
	end

	assign entry_sel = bank_sel ? entry1 : entry0;

	// follow bit only means something for ram entries
	assign follow = entry_sel[paging_pkg::BIT_RAM] & entry_sel[paging_pkg::BIT_FOLLOW];

	assign pent_ram_page = {{(paging_pkg::PAGE_W-3){1'b0}}, pent_page};

	// pages 0..3 are dos 48, dos 128, basic 128, basic 48
	assign pent_rom_page = {{(paging_pkg::PAGE_W-2){1'b0}}, ~dos, pent_rom};

	////////////////////////////////////////////////////////////////////////////
	// mapping
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (pager_on)
		begin
			cur_ram = entry_sel[paging_pkg::BIT_RAM];
			if (follow)
				cur_page = pent_ram_page;
			else
				cur_page = {2'b00, entry_sel[5:0]};
		end
		else
		begin
			// fixed pentagon layout
			case (WIN_INDEX)
				0:
				begin
					cur_ram  = 1'b0;
					cur_page = pent_rom_page;
				end
				1:
				begin
					cur_ram  = 1'b1;
					cur_page = paging_pkg::DEFAULT_PAGE_WIN1;
				end
				2:
				begin
					cur_ram  = 1'b1;
					cur_page = paging_pkg::DEFAULT_PAGE_WIN2;
				end
				default:
				begin
					cur_ram  = 1'b1;
					cur_page = pent_ram_page;
				end
			endcase
		end
	end

endmodule

/* source/pager_port_decode.sv */
`timescale 1ns/1ps

module pager_port_decode (
	input  logic                                   fclk,
	input  logic                                   rst,

	// z80 port write
	input  logic [15:0]                            za,
	input  logic [7:0]                             zd_in,
	input  logic                                   port_wr,

	// to the window pagers
	output logic [paging_pkg::NUM_WINDOWS-1:0]     page_wr,
	output logic [paging_pkg::PAGE_W-1:0]          page_wdata,
	output logic                                   bank_sel,
	output logic                                   pager_on,
	output logic [2:0]                             pent_page,
	output logic                                   pent_rom
);

	logic wr_7ffd;
	logic wr_enable;
	logic wr_page;
	logic p7ffd_lock;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	// 7FFD needs the full address, the others only the low byte
	assign wr_7ffd   = port_wr && (za == paging_pkg::PORT_7FFD);
	assign wr_enable = port_wr && (za[7:0] == paging_pkg::PORT_LO_ENABLE);
	assign wr_page   = port_wr && (za[7:0] == paging_pkg::PORT_LO_PAGE);

	// one strobe for the window in za[15:14]
	always_comb
	begin
		page_wr = '0;
		if (wr_page)
			page_wr[za[15:paging_pkg::WIN_OFFSET_W]] = 1'b1;
	end

	assign page_wdata = zd_in;

	////////////////////////////////////////////////////////////////////////////
	// 7FFD register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			pent_page  <= '0;
			pent_rom   <= 1'b0;
			p7ffd_lock <= 1'b0;
		end
		else if (wr_7ffd && !p7ffd_lock)
		begin
			pent_page  <= zd_in[2:0];
			pent_rom   <= zd_in[paging_pkg::P7FFD_ROM_BIT];
			// once set, only reset clears it
			p7ffd_lock <= zd_in[paging_pkg::P7FFD_LOCK_BIT];
		end
	end

	// rom bit also picks which entry bank the pagers use
	assign bank_sel = pent_rom;

	// pager enable
	always_ff @(posedge fclk)
	begin
		if (rst)
			pager_on <= 1'b0;
		else if (wr_enable)
			pager_on <= zd_in[0];
	end

endmodule

/* source/paging_pkg.sv */
package paging_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	// one page byte per window entry
	localparam int PAGE_W       = 8;
	// byte offset inside a 16 KB window
	localparam int WIN_OFFSET_W = 14;
	// page number above window offset
	localparam int PHYS_ADDR_W  = PAGE_W + WIN_OFFSET_W;
	// selected by za[15:14]
	localparam int NUM_WINDOWS  = 4;

	////////////////////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////////////////////

	localparam logic [15:0] PORT_7FFD        = 16'h7FFD;
	localparam logic [7:0]  PORT_LO_PAGE     = 8'hF7;
	localparam logic [7:0]  PORT_LO_ENABLE   = 8'h77;
	localparam logic [7:0]  PORT_LO_READBACK = 8'hBE;

	// M1 fetch from 3Dxx in the basic ROM enters TR-DOS
	localparam logic [7:0]  DOS_TRAP_HI      = 8'h3D;

	// page byte fields
	localparam int BIT_RAM    = 6;
	localparam int BIT_FOLLOW = 7;

	// 7FFD fields
	localparam int P7FFD_ROM_BIT  = 4;
	localparam int P7FFD_LOCK_BIT = 5;

	// pentagon layout of windows 1 and 2
	localparam logic [PAGE_W-1:0] DEFAULT_PAGE_WIN1 = 8'd5;
	localparam logic [PAGE_W-1:0] DEFAULT_PAGE_WIN2 = 8'd2;

endpackage
